// File: common/rvv_cfg_pkg.sv
package rvv_cfg_pkg;

  // Vector register width in bits
  localparam int VLEN = 128;

  // Same width counted in bytes, one strobe bit per byte
  localparam int VLENB = VLEN / 8;

  // Architectural vector registers v0..v31
  localparam int VREG_NUM = 32;

  // Retire bandwidth, entries per cycle
  localparam int NUM_RT_UOP = 4;

  // Width of a retire count, 0 up to NUM_RT_UOP inclusive
  localparam int RT_CNT_W = $clog2(NUM_RT_UOP + 1);

  // Default reorder queue depth, must stay a power of two
  localparam int ROB_DEPTH_DEF = 8;

endpackage

// File: common/rvv_uop_pkg.sv
package rvv_uop_pkg;

  // Program counter of the micro-op
  typedef logic [31:0] pc_t;

  // Destination vector register index
  typedef logic [$clog2(rvv_cfg_pkg::VREG_NUM)-1:0] vreg_idx_t;

  // One full vector register
  typedef logic [rvv_cfg_pkg::VLEN-1:0] vdata_t;

  // Byte enables, bit b covers data bits [8*b+7:8*b]
  typedef logic [rvv_cfg_pkg::VLENB-1:0] vstrb_t;

  // Completed micro-op waiting for retirement
  typedef struct packed {
    pc_t       uop_pc;
    vreg_idx_t rt_index;
    vdata_t    rt_data;
    vstrb_t    rt_strobe;
    // Saturation seen during execution, goes to vxsat on retire
    logic      vxsat;
  } rt_entry_t;

endpackage

// File: logic/rob_queue.sv
`timescale 1ns/1ps

module rob_queue #(
  parameter int ROB_DEPTH = rvv_cfg_pkg::ROB_DEPTH_DEF
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // Push side
  input  logic                                   uop_valid,
  input  rvv_uop_pkg::rt_entry_t                 uop_entry,
  output logic                                   uop_ready,
  // Head window towards retire, slot 0 oldest
  output logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]     head_valid,
  output rvv_uop_pkg::rt_entry_t                 head_entry [rvv_cfg_pkg::NUM_RT_UOP],
  input  logic [rvv_cfg_pkg::RT_CNT_W-1:0]       pop_count
);

  localparam int PTR_W = $clog2(ROB_DEPTH);
  localparam int CNT_W = $clog2(ROB_DEPTH + 1);

  rvv_uop_pkg::rt_entry_t mem [ROB_DEPTH];

  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic             push;

  // Full exactly when every slot is taken
  assign uop_ready = (count != CNT_W'(ROB_DEPTH));
  assign push      = uop_valid && uop_ready;

  // Entry storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= uop_entry;
    end
  end

  // Pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      rd_ptr <= rd_ptr + PTR_W'(pop_count);
      // Retire never pops more than the valid prefix
      count  <= count + CNT_W'(push) - CNT_W'(pop_count);
    end
  end

  // Oldest entries with wrap-around, valid bits follow occupancy
  always_comb begin
    for (int i = 0; i < rvv_cfg_pkg::NUM_RT_UOP; i++) begin
      head_valid[i] = (i < int'(count));
      head_entry[i] = mem[rd_ptr + PTR_W'(i)];
    end
  end

endmodule

// File: logic/rt_retire.sv
`timescale 1ns/1ps

module rt_retire (
  // Head window from the reorder queue
  input  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]   head_valid,
  input  rvv_uop_pkg::rt_entry_t               head_entry [rvv_cfg_pkg::NUM_RT_UOP],
  output logic [rvv_cfg_pkg::RT_CNT_W-1:0]     pop_count,
  // Retire report
  output logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]   rt_valid,
  output rvv_uop_pkg::pc_t                     rt_pc [rvv_cfg_pkg::NUM_RT_UOP],
  // Vxsat update handshake
  output logic                                 wr_vxsat_valid,
  input  logic                                 wr_vxsat_ready,
  // Register file write port, one lane per register
  output rvv_uop_pkg::vstrb_t                  vrf_wenb_full  [rvv_cfg_pkg::VREG_NUM],
  output rvv_uop_pkg::vdata_t                  vrf_wdata_full [rvv_cfg_pkg::VREG_NUM]
);

  // Retire prefix and vxsat request
  always_comb begin
    logic stop;
    logic any_sat;

    stop      = 1'b0;
    any_sat   = 1'b0;
    pop_count = '0;
    for (int i = 0; i < rvv_cfg_pkg::NUM_RT_UOP; i++) begin
      // Prefix ends at the first empty slot
      if (!head_valid[i]) begin
        stop = 1'b1;
      end
      // Saturating entry cannot go while vxsat is back-pressured
      if (head_valid[i] && head_entry[i].vxsat && !wr_vxsat_ready) begin
        stop = 1'b1;
      end
      rt_valid[i] = !stop;
      rt_pc[i]    = rt_valid[i] ? head_entry[i].uop_pc : '0;
      if (rt_valid[i] && head_entry[i].vxsat) begin
        any_sat = 1'b1;
      end
      pop_count = pop_count + rvv_cfg_pkg::RT_CNT_W'(rt_valid[i]);
    end
    wr_vxsat_valid = any_sat;
  end

  // Byte merge, oldest slot first so younger writers override
  always_comb begin
    rvv_uop_pkg::vreg_idx_t idx;

    for (int r = 0; r < rvv_cfg_pkg::VREG_NUM; r++) begin
      vrf_wenb_full[r]  = '0;
      vrf_wdata_full[r] = '0;
    end
    for (int i = 0; i < rvv_cfg_pkg::NUM_RT_UOP; i++) begin
      idx = head_entry[i].rt_index;
      if (rt_valid[i]) begin
        for (int b = 0; b < rvv_cfg_pkg::VLENB; b++) begin
          if (head_entry[i].rt_strobe[b]) begin
            vrf_wenb_full[idx][b]        = 1'b1;
            vrf_wdata_full[idx][b*8 +: 8] = head_entry[i].rt_data[b*8 +: 8];
          end
        end
      end
    end
  end

endmodule

// File: logic/rt_vrf.sv
`timescale 1ns/1ps

module rt_vrf (
  input  logic                   clk,
  input  logic                   rst_n,
  // Write lanes from retire
  input  rvv_uop_pkg::vstrb_t    vrf_wenb_full  [rvv_cfg_pkg::VREG_NUM],
  input  rvv_uop_pkg::vdata_t    vrf_wdata_full [rvv_cfg_pkg::VREG_NUM],
  // Read port
  input  rvv_uop_pkg::vreg_idx_t vrf_rd_index,
  output rvv_uop_pkg::vdata_t    vrf_rd_data
);

  rvv_uop_pkg::vdata_t vreg [rvv_cfg_pkg::VREG_NUM];

  // All registers read zero out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < rvv_cfg_pkg::VREG_NUM; r++) begin
        vreg[r] <= '0;
      end
    end else begin
      for (int r = 0; r < rvv_cfg_pkg::VREG_NUM; r++) begin
        for (int b = 0; b < rvv_cfg_pkg::VLENB; b++) begin
          if (vrf_wenb_full[r][b]) begin
            vreg[r][b*8 +: 8] <= vrf_wdata_full[r][b*8 +: 8];
          end
        end
      end
    end
  end

  // Combinational read, sees a write right after its edge
  assign vrf_rd_data = vreg[vrf_rd_index];

endmodule

// File: logic/rvv_retire_top.sv
`timescale 1ns/1ps

module rvv_retire_top #(
  parameter int ROB_DEPTH = rvv_cfg_pkg::ROB_DEPTH_DEF
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  // Completed micro-ops in
  input  logic                                 uop_valid,
  input  rvv_uop_pkg::rt_entry_t               uop_entry,
  output logic                                 uop_ready,
  // Retire report
  output logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]   rt_valid,
  output rvv_uop_pkg::pc_t                     rt_pc [rvv_cfg_pkg::NUM_RT_UOP],
  // Vxsat handshake
  output logic                                 wr_vxsat_valid,
  input  logic                                 wr_vxsat_ready,
  // Register file read
  input  rvv_uop_pkg::vreg_idx_t               vrf_rd_index,
  output rvv_uop_pkg::vdata_t                  vrf_rd_data
);

  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0] head_valid;
  rvv_uop_pkg::rt_entry_t             head_entry [rvv_cfg_pkg::NUM_RT_UOP];
  logic [rvv_cfg_pkg::RT_CNT_W-1:0]   pop_count;
  rvv_uop_pkg::vstrb_t                vrf_wenb_full  [rvv_cfg_pkg::VREG_NUM];
  rvv_uop_pkg::vdata_t                vrf_wdata_full [rvv_cfg_pkg::VREG_NUM];

  rob_queue #(
    .ROB_DEPTH (ROB_DEPTH)
  ) u_rob_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .uop_valid  (uop_valid),
    .uop_entry  (uop_entry),
    .uop_ready  (uop_ready),
    .head_valid (head_valid),
    .head_entry (head_entry),
    .pop_count  (pop_count)
  );

  rt_retire u_rt_retire (
    .head_valid     (head_valid),
    .head_entry     (head_entry),
    .pop_count      (pop_count),
    .rt_valid       (rt_valid),
    .rt_pc          (rt_pc),
    .wr_vxsat_valid (wr_vxsat_valid),
    .wr_vxsat_ready (wr_vxsat_ready),
    .vrf_wenb_full  (vrf_wenb_full),
    .vrf_wdata_full (vrf_wdata_full)
  );

  rt_vrf u_rt_vrf (
    .clk            (clk),
    .rst_n          (rst_n),
    .vrf_wenb_full  (vrf_wenb_full),
    .vrf_wdata_full (vrf_wdata_full),
    .vrf_rd_index   (vrf_rd_index),
    .vrf_rd_data    (vrf_rd_data)
  );

endmodule

// File: testbench/rvv_retire_assert.sv
`timescale 1ns/1ps

module rvv_retire_assert (
  input logic                                 clk,
  input logic                                 rst_n,
  input logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]   head_valid,
  input rvv_uop_pkg::rt_entry_t               head_entry [rvv_cfg_pkg::NUM_RT_UOP],
  input logic [rvv_cfg_pkg::RT_CNT_W-1:0]     pop_count,
  input logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]   rt_valid,
  input logic                                 wr_vxsat_ready
);

  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0] retired_sat;

  // Saturating entries in the retire group
  always_comb begin
    for (int i = 0; i < rvv_cfg_pkg::NUM_RT_UOP; i++) begin
      retired_sat[i] = rt_valid[i] && head_entry[i].vxsat;
    end
  end

  head_prefix: assert property (@(posedge clk) disable iff (!rst_n)
    (head_valid & (head_valid + 1'b1)) == '0)
    else $error("head_valid is not a prefix of ones");

  pop_in_prefix: assert property (@(posedge clk) disable iff (!rst_n)
    int'(pop_count) <= $countones(head_valid))
    else $error("pop_count is larger than the valid head window");

  no_sat_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !wr_vxsat_ready |-> retired_sat == '0)
    else $error("saturating entry retired while vxsat write was not ready");

endmodule

// Watches the nets between the reorder queue and the retire stage
bind rvv_retire_top rvv_retire_assert u_retire_assert (
  .clk            (clk),
  .rst_n          (rst_n),
  .head_valid     (head_valid),
  .head_entry     (head_entry),
  .pop_count      (pop_count),
  .rt_valid       (rt_valid),
  .wr_vxsat_ready (wr_vxsat_ready)
);

// File: testbench/rvv_retire_tb.sv
`timescale 1ns/1ps

module rvv_retire_tb;

  localparam int ROB_DEPTH   = rvv_cfg_pkg::ROB_DEPTH_DEF;
  localparam int NRT         = rvv_cfg_pkg::NUM_RT_UOP;
  localparam int NUM_PUSH    = 32 + 8 + 12 + 300;
  localparam int CYCLE_LIMIT = NUM_PUSH * 4 + 200;

  logic                   clk;
  logic                   rst_n;
  logic                   uop_valid;
  rvv_uop_pkg::rt_entry_t uop_entry;
  logic                   uop_ready;
  logic [NRT-1:0]         rt_valid;
  rvv_uop_pkg::pc_t       rt_pc [NRT];
  logic                   wr_vxsat_valid;
  logic                   wr_vxsat_ready;
  rvv_uop_pkg::vreg_idx_t vrf_rd_index;
  rvv_uop_pkg::vdata_t    vrf_rd_data;

  // Reference model state
  rvv_uop_pkg::rt_entry_t exp_q [$];
  rvv_uop_pkg::vdata_t    ref_vreg [rvv_cfg_pkg::VREG_NUM];

  integer           seed;
  rvv_uop_pkg::pc_t next_pc;
  string            test_name;
  int               value_errs;
  int               other_errs;
  int               cycles;
  int               sent;
  logic             took;

  rvv_retire_top #(
    .ROB_DEPTH (ROB_DEPTH)
  ) uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .uop_valid      (uop_valid),
    .uop_entry      (uop_entry),
    .uop_ready      (uop_ready),
    .rt_valid       (rt_valid),
    .rt_pc          (rt_pc),
    .wr_vxsat_valid (wr_vxsat_valid),
    .wr_vxsat_ready (wr_vxsat_ready),
    .vrf_rd_index   (vrf_rd_index),
    .vrf_rd_data    (vrf_rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the run did not finish", cycles);
    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    $display("Test failures found");
    $finish;
  end

  task automatic check_pc(input string what, input rvv_uop_pkg::pc_t exp,
                          input rvv_uop_pkg::pc_t act);
    if (exp !== act) begin
      value_errs++;
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_vreg(input string what, input rvv_uop_pkg::vdata_t exp,
                            input rvv_uop_pkg::vdata_t act);
    if (exp !== act) begin
      value_errs++;
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      value_errs++;
      $display("[ERROR] %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  // Enabled bytes of the entry replace the old register bytes
  function automatic rvv_uop_pkg::vdata_t merge_bytes(input rvv_uop_pkg::vdata_t old,
                                                      input rvv_uop_pkg::rt_entry_t e);
    rvv_uop_pkg::vdata_t res;
    res = old;
    for (int b = 0; b < rvv_cfg_pkg::VLENB; b++) begin
      if (e.rt_strobe[b]) begin
        res[b*8 +: 8] = e.rt_data[b*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic rvv_uop_pkg::rt_entry_t make_entry(input rvv_uop_pkg::vreg_idx_t idx,
                                                        input rvv_uop_pkg::vstrb_t strb,
                                                        input logic sat);
    rvv_uop_pkg::rt_entry_t e;
    e.uop_pc    = next_pc;
    next_pc     = next_pc + 32'd4;
    e.rt_index  = idx;
    e.rt_strobe = strb;
    e.vxsat     = sat;
    for (int w = 0; w < rvv_cfg_pkg::VLEN / 32; w++) begin
      e.rt_data[w*32 +: 32] = $random(seed);
    end
    return e;
  endfunction

  // Predict this cycle's retire group, then record the pending push
  always @(negedge clk) begin
    int   exp_n;
    logic exp_sat;
    if (rst_n) begin
      exp_n   = 0;
      exp_sat = 1'b0;
      for (int i = 0; i < NRT; i++) begin
        if (exp_n == i && i < exp_q.size()) begin
          if (wr_vxsat_ready || !exp_q[i].vxsat) begin
            exp_n = i + 1;
          end
        end
      end
      check_flag("uop_ready", exp_q.size() < ROB_DEPTH, uop_ready);
      for (int i = 0; i < NRT; i++) begin
        if (rt_valid[i] && i >= exp_q.size()) begin
          other_errs++;
          $display("Extra retirement in slot %0d (pc %h) with nothing left to retire",
                   i, rt_pc[i]);
        end
        check_flag($sformatf("rt_valid[%0d]", i), i < exp_n, rt_valid[i]);
        if (i < exp_n) begin
          check_pc($sformatf("rt_pc[%0d]", i), exp_q[i].uop_pc, rt_pc[i]);
        end
      end
      for (int i = 0; i < exp_n; i++) begin
        ref_vreg[exp_q[0].rt_index] = merge_bytes(ref_vreg[exp_q[0].rt_index], exp_q[0]);
        exp_sat = exp_sat | exp_q[0].vxsat;
        void'(exp_q.pop_front());
      end
      check_flag("wr_vxsat_valid", exp_sat, wr_vxsat_valid);
      if (uop_valid && uop_ready) begin
        exp_q.push_back(uop_entry);
      end
    end
  end

  // Hold one entry on the inputs until the queue accepts it
  task automatic push_entry(input rvv_uop_pkg::rt_entry_t e);
    uop_valid = 1'b1;
    uop_entry = e;
    @(negedge clk);
    while (!uop_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    uop_valid = 1'b0;
  endtask

  // Wait until the DUT stops retiring and the last write has landed
  task automatic drain_queue;
    uop_valid      = 1'b0;
    wr_vxsat_ready = 1'b1;
    @(negedge clk);
    while (rt_valid !== '0) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    if (exp_q.size() != 0) begin
      other_errs++;
      $display("%0d pushed entries were never retired", exp_q.size());
    end
  endtask

  task automatic sweep_vregs;
    for (int r = 0; r < rvv_cfg_pkg::VREG_NUM; r++) begin
      vrf_rd_index = rvv_uop_pkg::vreg_idx_t'(r);
      @(negedge clk);
      check_vreg($sformatf("v%0d", r), ref_vreg[r], vrf_rd_data);
      @(posedge clk);
      #2;
    end
  endtask

  initial begin
    seed           = 32'h94a0;
    next_pc        = 32'h0000_1000;
    value_errs     = 0;
    other_errs     = 0;
    rst_n          = 1'b0;
    uop_valid      = 1'b0;
    uop_entry      = '0;
    wr_vxsat_ready = 1'b1;
    vrf_rd_index   = '0;
    for (int r = 0; r < rvv_cfg_pkg::VREG_NUM; r++) begin
      ref_vreg[r] = '0;
    end
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;

    test_name = "reset";
    sweep_vregs();

    test_name = "full_write";
    for (int r = 0; r < rvv_cfg_pkg::VREG_NUM; r++) begin
      push_entry(make_entry(rvv_uop_pkg::vreg_idx_t'(r), '1, 1'b0));
    end
    drain_queue();
    sweep_vregs();

    // Saturating head holds the group so several writers retire together
    test_name = "byte_merge";
    wr_vxsat_ready = 1'b0;
    push_entry(make_entry(7, rvv_uop_pkg::vstrb_t'($random(seed)), 1'b1));
    for (int k = 0; k < 7; k++) begin
      push_entry(make_entry(rvv_uop_pkg::vreg_idx_t'(7 + k % 2),
                            rvv_uop_pkg::vstrb_t'($random(seed)), 1'b0));
    end
    drain_queue();
    sweep_vregs();

    test_name = "vxsat_stall";
    wr_vxsat_ready = 1'b0;
    fork
      for (int k = 0; k < 12; k++) begin
        push_entry(make_entry(rvv_uop_pkg::vreg_idx_t'(8 + k % 4),
                              rvv_uop_pkg::vstrb_t'($random(seed)), k % 3 == 2));
      end
      begin
        @(negedge clk);
        while (uop_ready) begin
          @(negedge clk);
        end
        repeat (4) @(posedge clk);
        #2;
        wr_vxsat_ready = 1'b1;
      end
    join
    drain_queue();
    sweep_vregs();

    test_name = "random";
    sent      = 0;
    uop_valid = 1'b0;
    while (sent < 300) begin
      if (!uop_valid) begin
        uop_entry = make_entry(rvv_uop_pkg::vreg_idx_t'($random(seed)),
                               rvv_uop_pkg::vstrb_t'($random(seed)), 1'b0);
        uop_entry.vxsat = ($random(seed) & 7) == 0;
        uop_valid = 1'b1;
      end
      wr_vxsat_ready = ($random(seed) & 3) != 0;
      @(negedge clk);
      took = uop_ready;
      @(posedge clk);
      #2;
      if (took) begin
        uop_valid = 1'b0;
        sent++;
      end
    end
    drain_queue();
    sweep_vregs();

    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: verilog.f
common/rvv_cfg_pkg.sv
common/rvv_uop_pkg.sv
logic/rob_queue.sv
logic/rt_retire.sv
logic/rt_vrf.sv
logic/rvv_retire_top.sv
testbench/rvv_retire_assert.sv
testbench/rvv_retire_tb.sv

// File: Bender.yml
package:
  name: rvv_retire

sources:
  - common/rvv_cfg_pkg.sv
  - common/rvv_uop_pkg.sv
  - logic/rob_queue.sv
  - logic/rt_retire.sv
  - logic/rt_vrf.sv
  - logic/rvv_retire_top.sv
  - target: test
    files:
      - testbench/rvv_retire_assert.sv
      - testbench/rvv_retire_tb.sv
